/* design/rv_consts.svh */
/*
 * Core-wide constants for the single-cycle RV32I core
 * Data width, register count and reset fetch address
 */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Data and address width, one word
`define RV_XLEN 32

// Architectural integer registers, x0 included
`define RV_REG_COUNT 32

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif

/* design/rv_isa_pkg.sv */
/*
 * Instruction-level types of the RV32I core
 * Major opcodes and ALU operation codes
 */
package rv_isa_pkg;

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OP     = 7'b0110011,   // Register-register
        OP_IMM = 7'b0010011,   // Register-immediate
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcodeE;

    // ALU operations
    typedef enum logic [3:0] {
        ADD   = 4'b0000,
        SUB   = 4'b0001,
        SLL   = 4'b0010,
        SLT   = 4'b0011,   // Signed compare
        SLTU  = 4'b0100,   // Unsigned compare
        XOR   = 4'b0101,
        SRL   = 4'b0110,
        SRA   = 4'b0111,
        OR    = 4'b1000,
        AND   = 4'b1001,
        PASSB = 4'b1010,   // Operand b straight through, lui
        NONE  = 4'b1111    // Result forced to zero
    } aluOpE;

endpackage

/* design/rv_ctrl_pkg.sv */
/*
 * Datapath-control types of the RV32I core
 * Write-back source and memory access size
 */
package rv_ctrl_pkg;

    // Source of the register write-back value
    typedef enum logic [1:0] {
        ALU   = 2'b00,
        MEM   = 2'b01,   // Extended load data
        PC4   = 2'b10,   // Link value for jal and jalr
        PCIMM = 2'b11    // auipc
    } wbSelE;

    // Access size, value is byte count minus one
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b11
    } dataLenE;

endpackage

/* design/rvController.sv */
/*
 * Instruction decoder of the single-cycle core
 * Maps opcode, func3 and func7 onto every datapath control
 */
`timescale 1ns/1ps

module rvController (
    input  logic [6:0]           opcode,
    input  logic [2:0]           func3,
    input  logic [6:0]           func7,
    output rv_ctrl_pkg::wbSelE   memToReg,
    output logic                 memWrite,
    output logic                 branch,
    output logic                 jump,
    output rv_isa_pkg::aluOpE    aluControl,
    output logic                 regWrite,
    output rv_ctrl_pkg::dataLenE dataLen,
    output logic                 dataSign,
    output logic                 aluSrc
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    aluOpE aluFunc;   // Operation picked by func3 and func7

    // Function field decode shared by OP and OP_IMM
    always_comb begin
        case (func3)
            3'b000:  aluFunc = (opcode == OP && func7[5]) ? SUB : ADD;
            3'b001:  aluFunc = SLL;
            3'b010:  aluFunc = SLT;
            3'b011:  aluFunc = SLTU;
            3'b100:  aluFunc = XOR;
            3'b101:  aluFunc = func7[5] ? SRA : SRL;
            3'b110:  aluFunc = OR;
            default: aluFunc = AND;
        endcase
    end

    always_comb begin
        // Defaults describe an instruction with no effect
        memToReg   = ALU;
        memWrite   = 1'b0;
        branch     = 1'b0;
        jump       = 1'b0;
        aluControl = NONE;
        regWrite   = 1'b0;
        aluSrc     = 1'b0;

        case (opcode)
            OP: begin
                regWrite   = 1'b1;
                aluControl = aluFunc;
            end
            OP_IMM: begin
                regWrite   = 1'b1;
                aluSrc     = 1'b1;
                aluControl = aluFunc;
            end
            LOAD: begin
                regWrite   = 1'b1;
                memToReg   = MEM;
                aluSrc     = 1'b1;
                aluControl = ADD;   // Address rs1 + imm
            end
            STORE: begin
                memWrite   = 1'b1;
                aluSrc     = 1'b1;
                aluControl = ADD;
            end
            BRANCH: begin
                branch     = 1'b1;
                aluControl = SUB;   // Zero flag gives equality
            end
            JAL: begin
                jump     = 1'b1;
                regWrite = 1'b1;
                memToReg = PC4;
            end
            JALR: begin
                jump       = 1'b1;
                regWrite   = 1'b1;
                memToReg   = PC4;
                aluSrc     = 1'b1;
                aluControl = ADD;   // Target rs1 + imm
            end
            LUI: begin
                regWrite   = 1'b1;
                aluSrc     = 1'b1;
                aluControl = PASSB;
            end
            AUIPC: begin
                regWrite = 1'b1;
                memToReg = PCIMM;
            end
            default: ;   // Unknown opcode, no state change
        endcase
    end

    // Access size and signedness from func3
    always_comb begin
        case (func3[1:0])
            2'b00:   dataLen = BYTE;
            2'b01:   dataLen = HALF;
            default: dataLen = WORD;
        endcase
        dataSign = (opcode == LOAD) && !func3[2];   // lb, lh, lw
    end

endmodule

/* design/rvAlu.sv */
/*
 * Integer ALU
 * Add, subtract, logic, compare and shift on two words with a zero flag
 */
`timescale 1ns/1ps
`include "rv_consts.svh"

module rvAlu (
    input  logic [`RV_XLEN-1:0] a,
    input  logic [`RV_XLEN-1:0] b,
    input  rv_isa_pkg::aluOpE   op,
    output logic [`RV_XLEN-1:0] result,
    output logic                zero
);
    import rv_isa_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];   // Only the low five bits shift

    always_comb begin
        case (op)
            ADD:     result = a + b;
            SUB:     result = a - b;
            SLL:     result = a << shamt;
            SLT:     result = {{(`RV_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            SLTU:    result = {{(`RV_XLEN-1){1'b0}}, a < b};
            XOR:     result = a ^ b;
            SRL:     result = a >> shamt;
            SRA:     result = $unsigned($signed(a) >>> shamt);
            OR:      result = a | b;
            AND:     result = a & b;
            PASSB:   result = b;
            default: result = '0;   // NONE
        endcase
    end

    assign zero = (result == '0);

endmodule

/* design/rvImmGen.sv */
/*
 * Immediate generator
 * Rebuilds the sign-extended I, S, B, U or J immediate from the opcode
 */
`timescale 1ns/1ps
`include "rv_consts.svh"

module rvImmGen (
    input  logic [`RV_XLEN-1:0] instr,
    output logic [`RV_XLEN-1:0] imm
);
    import rv_isa_pkg::*;

    always_comb begin
        case (instr[6:0])
            OP_IMM, LOAD, JALR:
                imm = {{20{instr[31]}}, instr[31:20]};
            STORE:
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            BRANCH:   // Bit 0 always zero
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            LUI, AUIPC:
                imm = {instr[31:12], 12'h000};
            JAL:
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            default:
                imm = '0;   // OP and unknown opcodes
        endcase
    end

endmodule

/* design/rvRegFile.sv */
/*
 * Integer register file
 * Two combinational read ports, one write port on the clock edge, x0 reads zero
 */
`timescale 1ns/1ps
`include "rv_consts.svh"

module rvRegFile (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic [$clog2(`RV_REG_COUNT)-1:0]  rs1,
    input  logic [$clog2(`RV_REG_COUNT)-1:0]  rs2,
    input  logic [$clog2(`RV_REG_COUNT)-1:0]  rd,
    input  logic [`RV_XLEN-1:0]               wdata,
    input  logic                              we,
    output logic [`RV_XLEN-1:0]               rdata1,
    output logic [`RV_XLEN-1:0]               rdata2
);
    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin   // x0 never written
            regs[rd] <= wdata;
        end
    end

    // Same-cycle write not forwarded
    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

endmodule

/* design/rvLoadStore.sv */
/*
 * Load and store lane handling
 * Store data replication and byte mask, load lane extraction and extension
 */
`timescale 1ns/1ps
`include "rv_consts.svh"

module rvLoadStore (
    input  logic [1:0]           addr,
    input  rv_ctrl_pkg::dataLenE dataLen,
    input  logic                 dataSign,
    input  logic                 memWrite,
    input  logic [`RV_XLEN-1:0]  storeData,
    input  logic [`RV_XLEN-1:0]  rdata,
    output logic [`RV_XLEN-1:0]  wdata,
    output logic [3:0]           wmask,
    output logic [`RV_XLEN-1:0]  loadData
);
    import rv_ctrl_pkg::*;

    logic [3:0]          laneMask;
    logic [`RV_XLEN-1:0] shifted;   // Addressed lane moved to bit 0

    // Store path
    always_comb begin
        case (dataLen)
            BYTE: begin
                wdata    = {4{storeData[7:0]}};
                laneMask = 4'b0001 << addr;
            end
            HALF: begin
                wdata    = {2{storeData[15:0]}};
                laneMask = 4'b0011 << {addr[1], 1'b0};
            end
            default: begin
                wdata    = storeData;
                laneMask = 4'b1111;
            end
        endcase
    end

    assign wmask = memWrite ? laneMask : 4'b0000;

    // Load path
    assign shifted = rdata >> {addr, 3'b000};

    always_comb begin
        case (dataLen)
            BYTE:    loadData = {{24{dataSign & shifted[7]}}, shifted[7:0]};
            HALF:    loadData = {{16{dataSign & shifted[15]}}, shifted[15:0]};
            default: loadData = rdata;
        endcase
    end

endmodule

/* design/rvCore.sv */
/*
 * Single-cycle RV32I core
 * PC register, next-PC selection, operand and write-back muxes around the datapath
 */
`timescale 1ns/1ps
`include "rv_consts.svh"

module rvCore (
    input  logic                clk,
    input  logic                rstN,
    input  logic [`RV_XLEN-1:0] instr,
    input  logic [`RV_XLEN-1:0] dataRdata,
    output logic [`RV_XLEN-1:0] pc,
    output logic [`RV_XLEN-1:0] dataAddr,
    output logic [`RV_XLEN-1:0] dataWdata,
    output logic [3:0]          dataWmask,
    output logic                dataWe
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    wbSelE               memToReg;
    aluOpE               aluControl;
    dataLenE             dataLen;
    logic                memWrite;
    logic                branch;
    logic                jump;
    logic                regWrite;
    logic                dataSign;
    logic                aluSrc;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] rdata1;
    logic [`RV_XLEN-1:0] rdata2;
    logic [`RV_XLEN-1:0] aluB;
    logic [`RV_XLEN-1:0] aluResult;
    logic                aluZero;
    logic [`RV_XLEN-1:0] loadData;
    logic [`RV_XLEN-1:0] wbData;
    logic [`RV_XLEN-1:0] pcPlus4;
    logic [`RV_XLEN-1:0] pcPlusImm;
    logic [`RV_XLEN-1:0] nextPc;
    logic                branchTaken;
    logic                isJalr;

    rvController controller_i (
        .opcode(instr[6:0]), .func3(instr[14:12]), .func7(instr[31:25]),
        .memToReg, .memWrite, .branch, .jump, .aluControl,
        .regWrite, .dataLen, .dataSign, .aluSrc
    );

    rvImmGen immGen_i (.instr, .imm);

    rvRegFile regFile_i (
        .clk, .rstN,
        .rs1(instr[19:15]), .rs2(instr[24:20]), .rd(instr[11:7]),
        .wdata(wbData), .we(regWrite),
        .rdata1, .rdata2
    );

    assign aluB = aluSrc ? imm : rdata2;

    rvAlu alu_i (.a(rdata1), .b(aluB), .op(aluControl), .result(aluResult), .zero(aluZero));

    rvLoadStore loadStore_i (
        .addr(aluResult[1:0]), .dataLen, .dataSign, .memWrite,
        .storeData(rdata2), .rdata(dataRdata),
        .wdata(dataWdata), .wmask(dataWmask), .loadData
    );

    assign dataAddr = aluResult;
    assign dataWe   = memWrite & rstN;   // No writes while in reset

    assign pcPlus4   = pc + 32'd4;
    assign pcPlusImm = pc + imm;

    // beq on func3 bit 0 clear, bne on set
    assign branchTaken = branch & (aluZero ^ instr[12]);
    assign isJalr      = jump & (instr[6:0] == JALR);

    always_comb begin
        if (isJalr) begin
            nextPc = {aluResult[`RV_XLEN-1:1], 1'b0};
        end else if (jump || branchTaken) begin
            nextPc = pcPlusImm;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_comb begin
        case (memToReg)
            MEM:     wbData = loadData;
            PC4:     wbData = pcPlus4;     // Link address
            PCIMM:   wbData = pcPlusImm;
            default: wbData = aluResult;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= `RV_RESET_PC;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

/* dv/rvCoreBind_chk.sv */
/*
 * Bus and PC checks bound into the core
 * Word-aligned fetch, quiet data bus in reset, mask consistent with write enable
 */
`timescale 1ns/1ps
`include "rv_consts.svh"

module rvCoreBind_chk (
    input logic                clk,
    input logic                rstN,
    input logic [`RV_XLEN-1:0] pc,
    input logic [3:0]          dataWmask,
    input logic                dataWe
);
    pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
        else $error("pc %h not word aligned", pc);

    // No memory write may leak out while reset is held
    weLowInReset: assert property (@(posedge clk) !rstN |-> !dataWe)
        else $error("dataWe high during reset");

    maskMatchesWe: assert property (@(posedge clk) disable iff (!rstN)
                                    (dataWmask != 4'b0000) == dataWe)
        else $error("dataWmask %b disagrees with dataWe %b", dataWmask, dataWe);

    firstFetch: assert property (@(posedge clk) $rose(rstN) |-> pc == `RV_RESET_PC)
        else $error("first pc after reset is %h", pc);   // Fetch must start at reset PC

endmodule

bind rvCore rvCoreBind_chk chk_i (.clk, .rstN, .pc, .dataWmask, .dataWe);

/* dv/rvCoreTb.sv */
/*
 * Testbench of the single-cycle RV32I core
 * Builds a hand-encoded program, models both memories and checks every store
 */
`timescale 1ns/1ps

module rvCoreTb;
    import rv_isa_pkg::*;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  mask;
    } storeT;

    logic        clk;
    logic        rstN;
    logic [31:0] instr;
    logic [31:0] dataRdata;
    logic [31:0] pc;
    logic [31:0] dataAddr;
    logic [31:0] dataWdata;
    logic [3:0]  dataWmask;
    logic        dataWe;

    logic [31:0] imem [256];
    logic [31:0] dmem [64];
    storeT       expQ [$];
    storeT       head;
    int          progLen;
    int          resCnt;
    int          seed;

    rvCore rvCore_i (
        .clk, .rstN, .instr, .dataRdata,
        .pc, .dataAddr, .dataWdata, .dataWmask, .dataWe
    );

    always #4 clk = ~clk;

    // Both memories answer in the same cycle
    assign instr     = imem[pc[9:2]];
    assign dataRdata = dmem[dataAddr[7:2]];

    function automatic logic [31:0] fillWord(int i);
        return (i + 1) * 32'h9E37_79B9;   // Sign bits set in some bytes and halves
    endfunction

    function automatic logic [31:0] mergeBytes(logic [31:0] old, logic [31:0] data,
                                               logic [3:0] mask);
        logic [31:0] res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (mask[i]) res[8*i +: 8] = data[8*i +: 8];
        end
        return res;
    endfunction

    // RV32I results by func3, alt is func7 bit 5
    function automatic logic [31:0] aluRef(int f3, logic alt, logic [31:0] a, logic [31:0] b);
        case (f3)
            0:       return alt ? a - b : a + b;
            1:       return a << b[4:0];
            2:       return {31'd0, (a[31] != b[31]) ? a[31] : (a < b)};
            3:       return {31'd0, a < b};
            4:       return a ^ b;
            5:       return alt ? (a >> b[4:0]) | ({32{a[31]}} & ~(32'hFFFF_FFFF >> b[4:0]))
                            : a >> b[4:0];
            6:       return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] encI(int imm, int rs1, int f3, int rd, logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] encS(int imm, int rs2, int rs1, int f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], STORE};
    endfunction

    function automatic logic [31:0] encB(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], BRANCH};
    endfunction

    function automatic logic [31:0] encU(int imm, int rd, logic [6:0] op);
        return {imm[19:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] encJ(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], JAL};
    endfunction

    task automatic put(logic [31:0] word);
        imem[progLen[7:0]] = word;
        progLen++;
    endtask

    // sw of a register into the next result word, expected full mask
    task automatic storeReg(int rs, logic [31:0] value);
        put(encS(64 + 4 * resCnt, rs, 0, 2));
        expQ.push_back(storeT'{64 + 4 * resCnt, value, 4'hF});
        resCnt++;
    endtask

    task automatic loadConst(int rd, logic [31:0] value);
        logic [31:0] upper;
        upper = (value + 32'h800) >> 12;   // Compensates the sign of the addi part
        put(encU(upper, rd, LUI));
        put(encI(value, rd, 0, rd, OP_IMM));
    endtask

    task automatic stopFailed();
        $display("*** TEST FAILED ***");
        $fatal(1, "Run stopped on the first error");
    endtask

    always @(posedge clk) begin
        if (dataWe) dmem[dataAddr[7:2]] <= mergeBytes(dmem[dataAddr[7:2]], dataWdata, dataWmask);
    end

    // Every store must match the oldest expected one
    always @(posedge clk) begin
        if (rstN && dataWe) begin
            if (expQ.size() == 0) begin
                $display("Unexpected store to address %h at %0t", dataAddr, $time);
                stopFailed();
            end else begin
                head = expQ.pop_front();
                assert (dataAddr === head.addr && dataWdata === head.data
                        && dataWmask === head.mask) else begin
                    $display("FAIL %0t dataAddr/dataWdata/dataWmask expected %h/%h/%h actual %h/%h/%h",
                             $time, head.addr, head.data, head.mask,
                             dataAddr, dataWdata, dataWmask);
                    stopFailed();
                end
            end
        end else if (rstN && instr == 32'h0000_006F) begin   // jal x0, 0
            if (expQ.size() == 0) begin
                $display("*** TEST PASSED ***");
                $finish;
            end else begin
                $display("End loop reached with %0d stores still expected", expQ.size());
                stopFailed();
            end
        end
    end

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] lane;
        logic [31:0] data;
        logic [31:0] stray;
        logic [3:0]  mask;
        logic        alt;
        int          f3;
        int          at;
        clk     = 1'b0;
        rstN    = 1'b0;
        progLen = 0;
        resCnt  = 0;
        seed    = 9;
        for (int i = 0; i < 256; i++) begin
            imem[i[7:0]] = 32'h0000_006F;
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i[5:0]] = fillWord(i);
        end
        stray = encS(0, 1, 0, 2);   // Must never execute
        a = $random(seed);
        b = $random(seed);
        if (a == b) b = ~a;
        // Store at the reset PC, its write held off while reset is low
        storeReg(0, 32'h0000_0000);
        loadConst(1, a);
        loadConst(2, b);

        for (int k = 0; k < 10; k++) begin   // sub and sra come last
            f3  = (k < 8) ? k : ((k == 8) ? 0 : 5);
            alt = (k >= 8);
            put({alt ? 7'b0100000 : 7'b0000000, 5'd2, 5'd1, f3[2:0], 5'd3, OP});
            storeReg(3, aluRef(f3, alt, a, b));
        end
        for (int k = 0; k < 8; k++) begin
            if (k != 1 && k != 5) begin
                imm = $random(seed);
                imm = imm | 32'hFFFF_F800;   // Negative 12-bit immediate
                put(encI(imm, 1, k, 3, OP_IMM));
                storeReg(3, aluRef(k, 1'b0, a, imm));
            end
        end

        // Loads of each lane of word 0
        for (int off = 0; off < 4; off++) begin
            lane = fillWord(0) >> (8 * off);
            put(encI(off, 0, 0, 3, LOAD));
            storeReg(3, {{24{lane[7]}}, lane[7:0]});
            put(encI(off, 0, 4, 3, LOAD));
            storeReg(3, {24'd0, lane[7:0]});
            if (off % 2 == 0) begin
                put(encI(off, 0, 1, 3, LOAD));
                storeReg(3, {{16{lane[15]}}, lane[15:0]});
                put(encI(off, 0, 5, 3, LOAD));
                storeReg(3, {16'd0, lane[15:0]});
            end
        end
        put(encI(0, 0, 2, 3, LOAD));
        storeReg(3, fillWord(0));

        // sb at offsets 0..3 into words 4..7, sh at offsets 0 and 2 into words 8 and 9
        for (int k = 0; k < 6; k++) begin
            at   = (k < 4) ? 16 + 5 * k : ((k == 4) ? 32 : 38);
            mask = (k < 4) ? 4'b0001 << k : ((k == 4) ? 4'b0011 : 4'b1100);
            data = (k < 4) ? {4{a[7:0]}} : {2{a[15:0]}};
            put(encS(at, 1, 0, (k < 4) ? 0 : 1));
            expQ.push_back(storeT'{at, data, mask});
            put(encI(at & ~3, 0, 2, 3, LOAD));
            storeReg(3, mergeBytes(fillWord(at / 4), data, mask));
        end

        put(encB(8, 1, 1, 0));   // beq taken
        put(stray);
        put(encB(8, 2, 1, 1));   // bne taken
        put(stray);
        put(encB(8, 2, 1, 0));   // beq not taken
        storeReg(1, a);
        put(encB(8, 1, 1, 1));   // bne not taken
        storeReg(2, b);
        at = 4 * progLen;
        put(encJ(8, 5));
        put(stray);
        storeReg(5, at + 4);
        at = 4 * (progLen + 2);
        loadConst(6, at + 9);    // Odd target, jalr clears bit 0
        put(encI(0, 6, 0, 7, JALR));
        put(stray);
        storeReg(7, at + 4);

        imm = $random(seed);
        put(encU(imm, 3, LUI));
        storeReg(3, {imm[19:0], 12'h000});
        at = 4 * progLen;
        put(encU(imm, 3, AUIPC));
        storeReg(3, at + {imm[19:0], 12'h000});
        loadConst(4, b);
        put(32'hDEAD_B27F);      // Opcode 7'h7F, rd field x4
        storeReg(4, b);
        put(32'h0000_006F);

        repeat (10) @(negedge clk);
        rstN = 1'b1;
        // Watchdog, four cycles per instruction
        repeat (4 * progLen) @(posedge clk);
        $display("Timeout, the program never reached its end loop");
        stopFailed();
    end

endmodule

/* project.f */
+incdir+design
design/rv_isa_pkg.sv
design/rv_ctrl_pkg.sv
design/rvController.sv
design/rvAlu.sv
design/rvImmGen.sv
design/rvRegFile.sv
design/rvLoadStore.sv
design/rvCore.sv
dv/rvCoreBind_chk.sv
dv/rvCoreTb.sv

/* run.sh */
#!/bin/sh
# Build the core testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module rvCoreTb -f project.f -o rvCoreSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/rvCoreSim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi
exit 0
